// ==== hw/stream_unalign_defines.svh ====
/*
 * Stream unaligner width definitions
 * Unit, word, offset and length widths shared by the package and the RTL
 */

`ifndef STREAM_UNALIGN_DEFINES_SVH
`define STREAM_UNALIGN_DEFINES_SVH

// ---------------------------------------------------------------------
// Data unit and word geometry
// ---------------------------------------------------------------------

// One data unit, 4 bytes
`define STREAM_UNIT_BITS 32

// Full bus word, 16 bytes
`define STREAM_DATA_BITS 128

// Units per bus word
`define STREAM_UNITS (`STREAM_DATA_BITS / `STREAM_UNIT_BITS)

// ---------------------------------------------------------------------
// Control field widths
// ---------------------------------------------------------------------

// Shift amount in units, 0 to 3
`define STREAM_OFFSET_BITS 2

// Last word length in units, 0 stands for a full word
`define STREAM_LEN_BITS 2

// Offset plus last word length, sums up to 7
`define STREAM_TAIL_BITS 3

`endif

// ==== hw/stream_unalign_pkg.sv ====
/*
 * Stream unaligner types
 * Data unit, word, carry, offset and length types and the control states
 */

`default_nettype none

`include "stream_unalign_defines.svh"

package stream_unalign_pkg;

    // One data unit
    typedef logic [`STREAM_UNIT_BITS-1:0] unit_t;

    // Bus word, unit 0 in the low bits
    typedef unit_t [`STREAM_UNITS-1:0] data_t;

    // Units pushed past a word boundary, at most one less than a word
    typedef unit_t [`STREAM_UNITS-2:0] carry_t;

    // Shift amount in units
    typedef logic [`STREAM_OFFSET_BITS-1:0] offset_t;

    // Unit count of the last input word, 0 means a full word
    typedef logic [`STREAM_LEN_BITS-1:0] len_t;

    // Packet control states
    typedef enum logic [1:0] {
        state_wait,
        state_run,
        state_tail
    } shift_state_e;

endpackage : stream_unalign_pkg

`default_nettype wire

// ==== hw/shift_ctrl.sv ====
/*
 * Stream unaligner control
 * Wait/run/tail state machine, captures the packet offset and tail count
 * on the first beat and steers valid, ready and last around the datapath
 */

`timescale 1ns/1ps
`default_nettype none

`include "stream_unalign_defines.svh"

module shift_ctrl (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire stream_unalign_pkg::offset_t    offset,
    input  wire stream_unalign_pkg::len_t       len,
    input  wire logic                           in_valid,
    input  wire logic                           in_last,
    input  wire logic                           out_ready,
    output logic                                in_ready,
    output logic                                out_valid,
    output logic                                out_last,
    output stream_unalign_pkg::shift_state_e    state,
    output stream_unalign_pkg::offset_t         shift_offset
);

    // Wide enough for offset plus a full word
    typedef logic [`STREAM_TAIL_BITS-1:0] tail_t;

    // ---------------------------------------------------------------------
    // Captured packet parameters
    // ---------------------------------------------------------------------

    stream_unalign_pkg::offset_t offset_reg;
    tail_t                       tail_count;

    tail_t live_tail;
    logic  live_overflow;
    logic  reg_overflow;
    logic  in_accept;

    // Zero length encodes a full word
    function automatic tail_t last_word_len(input stream_unalign_pkg::len_t l);
        if (l == '0) begin
            return tail_t'(`STREAM_UNITS);
        end
        return tail_t'(l);
    endfunction

    assign in_accept = in_valid && in_ready;

    // Units of the last word land past the word boundary
    assign live_tail     = tail_t'(offset) + last_word_len(len);
    assign live_overflow = live_tail > tail_t'(`STREAM_UNITS);
    assign reg_overflow  = tail_count > tail_t'(`STREAM_UNITS);

    always_ff @(posedge clk) begin
        if (reset) begin
            offset_reg <= '0;
            tail_count <= '0;
        end else if (state == stream_unalign_pkg::state_wait && in_accept) begin
            // First beat of a packet
            offset_reg <= offset;
            tail_count <= live_tail;
        end
    end

    // ---------------------------------------------------------------------
    // Handshake steering
    // ---------------------------------------------------------------------

    always_comb begin
        // Straight pass by default
        out_valid    = in_valid;
        in_ready     = out_ready;
        out_last     = in_last;
        shift_offset = offset_reg;

        case (state)
            stream_unalign_pkg::state_wait: begin
                // Live offset until the first beat is taken
                shift_offset = offset;
                // Extra tail word will carry the last flag
                if (live_overflow) begin
                    out_last = 1'b0;
                end
            end
            stream_unalign_pkg::state_run: begin
                if (reg_overflow) begin
                    out_last = 1'b0;
                end
            end
            stream_unalign_pkg::state_tail: begin
                // Leftover units only, input stalled
                out_valid = 1'b1;
                in_ready  = 1'b0;
                out_last  = 1'b1;
            end
            default: begin
                out_valid = 1'b0;
                in_ready  = 1'b0;
                out_last  = 1'b0;
            end
        endcase
    end

    // ---------------------------------------------------------------------
    // State machine
    // ---------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stream_unalign_pkg::state_wait;
        end else begin
            case (state)
                stream_unalign_pkg::state_wait: begin
                    // Zero offset stays here and passes words through
                    if (in_accept && offset != '0) begin
                        if (!in_last) begin
                            state <= stream_unalign_pkg::state_run;
                        end else if (live_overflow) begin
                            // Single word packet spilling over
                            state <= stream_unalign_pkg::state_tail;
                        end
                    end
                end
                stream_unalign_pkg::state_run: begin
                    if (in_accept && in_last) begin
                        if (reg_overflow) begin
                            state <= stream_unalign_pkg::state_tail;
                        end else begin
                            state <= stream_unalign_pkg::state_wait;
                        end
                    end
                end
                stream_unalign_pkg::state_tail: begin
                    if (out_ready) begin
                        state <= stream_unalign_pkg::state_wait;
                    end
                end
                default: begin
                    state <= stream_unalign_pkg::state_wait;
                end
            endcase
        end
    end

endmodule : shift_ctrl

`default_nettype wire

// ==== hw/carry_store.sv ====
/*
 * Stream unaligner carry store
 * Keeps the top units of each accepted input word that the shift
 * pushes out of the current output word
 */

`timescale 1ns/1ps
`default_nettype none

`include "stream_unalign_defines.svh"

module carry_store (
    input  wire logic                           clk,
    input  wire stream_unalign_pkg::data_t      in_data,
    input  wire logic                           in_valid,
    input  wire logic                           in_ready,
    input  wire stream_unalign_pkg::offset_t    shift_offset,
    output stream_unalign_pkg::carry_t          carry
);

    stream_unalign_pkg::carry_t carry_next;

    // ---------------------------------------------------------------------
    // High slice select
    // ---------------------------------------------------------------------

    always_comb begin
        stream_unalign_pkg::offset_t src_idx;

        carry_next = '0;
        src_idx    = '0;
        for (int i = 0; i < `STREAM_UNITS - 1; i++) begin
            // Index wraps modulo the word, i minus offset lands on the top units
            src_idx = stream_unalign_pkg::offset_t'(i) - shift_offset;
            if (i < int'(shift_offset)) begin
                carry_next[i] = in_data[src_idx];
            end
        end
    end

    // ---------------------------------------------------------------------
    // Carry register
    // ---------------------------------------------------------------------

    // Loads on every accepted beat
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            carry <= carry_next;
        end
    end

endmodule : carry_store

`default_nettype wire

// ==== hw/unit_merge.sv ====
/*
 * Stream unaligner unit merger
 * Builds each output word from carried units and input units,
 * selected by control state and shift offset
 */

`timescale 1ns/1ps
`default_nettype none

`include "stream_unalign_defines.svh"

module unit_merge (
    input  wire stream_unalign_pkg::shift_state_e   state,
    input  wire stream_unalign_pkg::offset_t        shift_offset,
    input  wire stream_unalign_pkg::carry_t         carry,
    input  wire stream_unalign_pkg::data_t          in_data,
    output stream_unalign_pkg::data_t               out_data
);

    // Carry widened to a full word, top unit zero
    stream_unalign_pkg::data_t carry_word;

    always_comb begin
        carry_word = '0;
        carry_word[`STREAM_UNITS-2:0] = carry;
    end

    // ---------------------------------------------------------------------
    // Output word select
    // ---------------------------------------------------------------------

    always_comb begin
        stream_unalign_pkg::offset_t src_idx;

        out_data = in_data;
        src_idx  = '0;

        case (state)
            stream_unalign_pkg::state_wait,
            stream_unalign_pkg::state_run: begin
                for (int i = 0; i < `STREAM_UNITS; i++) begin
                    // Input unit that lands at position i
                    src_idx = stream_unalign_pkg::offset_t'(i) - shift_offset;
                    if (i >= int'(shift_offset)) begin
                        out_data[i] = in_data[src_idx];
                    end else if (state == stream_unalign_pkg::state_run) begin
                        // Units left over from the previous input word
                        out_data[i] = carry_word[i];
                    end else begin
                        // First word of a packet, nothing below the offset
                        out_data[i] = '0;
                    end
                end
            end
            stream_unalign_pkg::state_tail: begin
                out_data = carry_word;
            end
            default: begin
                out_data = in_data;
            end
        endcase
    end

endmodule : unit_merge

`default_nettype wire

// ==== hw/stream_unalign.sv ====
/*
 * Stream unaligner top level
 * Shifts a packet of 128-bit words up by 0 to 3 32-bit units,
 * adding a tail word when the last units spill over
 */

`timescale 1ns/1ps
`default_nettype none

`include "stream_unalign_defines.svh"

module stream_unalign (
    input  wire logic                           clk,
    input  wire logic                           reset,

    // Packet shift and last word length, held with the first beat
    input  wire stream_unalign_pkg::offset_t    offset,
    input  wire stream_unalign_pkg::len_t       len,

    // Input stream
    input  wire stream_unalign_pkg::data_t      in_data,
    input  wire logic                           in_valid,
    input  wire logic                           in_last,
    output logic                                in_ready,

    // Output stream
    output stream_unalign_pkg::data_t           out_data,
    output logic                                out_valid,
    output logic                                out_last,
    input  wire logic                           out_ready
);

    // ---------------------------------------------------------------------
    // Internal wires
    // ---------------------------------------------------------------------

    stream_unalign_pkg::shift_state_e   state;
    stream_unalign_pkg::offset_t        shift_offset;
    stream_unalign_pkg::carry_t         carry;

    // Packet FSM and handshake steering
    shift_ctrl shift_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .offset       (offset),
        .len          (len),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .out_ready    (out_ready),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .state        (state),
        .shift_offset (shift_offset)
    );

    // Units crossing the word boundary
    carry_store carry_store_inst (
        .clk          (clk),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .shift_offset (shift_offset),
        .carry        (carry)
    );

    // Output word assembly
    unit_merge unit_merge_inst (
        .state        (state),
        .shift_offset (shift_offset),
        .carry        (carry),
        .in_data      (in_data),
        .out_data     (out_data)
    );

endmodule : stream_unalign

`default_nettype wire

// ==== bench/stream_unalign_tb.sv ====
/*
 * Stream unaligner testbench
 * Random packets with random offsets and lengths, checked word by word
 * against a unit-stream model, with random back-pressure on the output
 */

`timescale 1ns/1ps
`default_nettype none

`include "stream_unalign_defines.svh"

module stream_unalign_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_PACKETS = 300;
    localparam int MAX_WORDS   = 6;
    // Room for one extra tail word per packet and slow back-pressure on every word
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * (MAX_WORDS + 1) * 10 + 200;

    logic                        clk;
    logic                        reset;
    stream_unalign_pkg::offset_t offset;
    stream_unalign_pkg::len_t    len;
    stream_unalign_pkg::data_t   in_data;
    logic                        in_valid;
    logic                        in_last;
    logic                        in_ready;
    stream_unalign_pkg::data_t   out_data;
    logic                        out_valid;
    logic                        out_last;
    logic                        out_ready;

    // ----------------------------------------------------------------------
    // Stimulus and model queues
    // ----------------------------------------------------------------------

    // Input beats with offset and len repeated on every beat of a packet
    stream_unalign_pkg::data_t   beat_data[$];
    logic                        beat_last[$];
    stream_unalign_pkg::offset_t beat_offset[$];
    stream_unalign_pkg::len_t    beat_len[$];

    // Expected output words and masks of the units that belong to the packet
    stream_unalign_pkg::data_t   exp_data[$];
    stream_unalign_pkg::data_t   exp_mask[$];
    logic                        exp_last[$];
    int                          exp_pkt[$];
    int                          exp_word[$];

    int tail_packets;
    int zero_offset_packets;
    int out_pkt;

    stream_unalign stream_unalign_inst (
        .clk       (clk),
        .reset     (reset),
        .offset    (offset),
        .len       (len),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    task automatic check_value(input string name,
                               input logic [`STREAM_DATA_BITS-1:0] expected,
                               input logic [`STREAM_DATA_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // Hang guard
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_run($sformatf("Timeout: packets not done after %0d cycles", TIMEOUT_CYCLES));
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Random packet plus the words the shift should produce from it
    task automatic build_packet(input int pkt);
        int                          nwords;
        int                          last_units;
        int                          nout;
        int                          idx;
        stream_unalign_pkg::offset_t off;
        stream_unalign_pkg::len_t    ln;
        stream_unalign_pkg::data_t   word;
        stream_unalign_pkg::data_t   mask;
        stream_unalign_pkg::unit_t   units[$];

        nwords     = 1 + int'($urandom % MAX_WORDS);
        off        = stream_unalign_pkg::offset_t'($urandom % 4);
        ln         = stream_unalign_pkg::len_t'($urandom % 4);
        last_units = (ln == '0) ? `STREAM_UNITS : int'(ln);
        nout       = nwords;

        // Shifted stream opens with offset zero units
        for (int u = 0; u < int'(off); u++) begin
            units.push_back('0);
        end
        for (int w = 0; w < nwords; w++) begin
            for (int u = 0; u < `STREAM_UNITS; u++) begin
                word[u] = $urandom;
            end
            beat_data.push_back(word);
            beat_last.push_back(w == nwords - 1);
            beat_offset.push_back(off);
            beat_len.push_back(ln);
            for (int u = 0; u < `STREAM_UNITS; u++) begin
                if (w < nwords - 1 || u < last_units) begin
                    units.push_back(word[u]);
                end
            end
            // Zero offset passes whole words including spare units
            if (off == '0) begin
                exp_data.push_back(word);
                exp_mask.push_back('1);
                exp_last.push_back(w == nwords - 1);
                exp_pkt.push_back(pkt);
                exp_word.push_back(w);
            end
        end

        if (off != '0) begin
            // Ceiling of offset plus unit count over the word size
            nout = (units.size() + `STREAM_UNITS - 1) / `STREAM_UNITS;
            for (int k = 0; k < nout; k++) begin
                word = '0;
                mask = '0;
                for (int u = 0; u < `STREAM_UNITS; u++) begin
                    idx = k * `STREAM_UNITS + u;
                    if (idx < units.size()) begin
                        word[u] = units[idx];
                        mask[u] = '1;
                    end
                end
                exp_data.push_back(word);
                exp_mask.push_back(mask);
                exp_last.push_back(k == nout - 1);
                exp_pkt.push_back(pkt);
                exp_word.push_back(k);
            end
        end else begin
            zero_offset_packets++;
        end
        if (nout > nwords) begin
            tail_packets++;
        end
    endtask

    function automatic stream_unalign_pkg::data_t junk_word();
        stream_unalign_pkg::data_t w;

        for (int u = 0; u < `STREAM_UNITS; u++) begin
            w[u] = $urandom;
        end
        return w;
    endfunction

    // Full rate first then lighter and heavier back-pressure
    function automatic int traffic_phase();
        if (out_pkt < NUM_PACKETS / 3) begin
            return 0;
        end else if (out_pkt < 2 * NUM_PACKETS / 3) begin
            return 1;
        end
        return 2;
    endfunction

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        bit    send;
        bit    holding;
        int    phase;
        string name;

        reset     = 1'b1;
        offset    = '0;
        len       = '0;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        send      = 1'b0;
        holding   = 1'b0;
        tail_packets        = 0;
        zero_offset_packets = 0;
        out_pkt             = 0;

        void'($urandom(32'h18c69ebd));
        for (int p = 0; p < NUM_PACKETS; p++) begin
            build_packet(p);
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset     = 1'b0;
        out_ready = 1'b1;

        // Idle input keeps the output quiet
        repeat (4) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            check_value("out_valid after reset", 128'(1'b0), 128'(out_valid));
        end

        while (beat_data.size() > 0 || exp_data.size() > 0) begin
            @(negedge clk);
            phase = traffic_phase();
            // A presented beat stays until taken
            if (!holding) begin
                send = beat_data.size() > 0 && (phase == 0 || ($urandom % 4) != 0);
            end
            if (send) begin
                in_data = beat_data[0];
                in_last = beat_last[0];
                offset  = beat_offset[0];
                len     = beat_len[0];
            end else begin
                in_data = junk_word();
                in_last = 1'b0;
            end
            in_valid = send;
            case (phase)
                0: out_ready = 1'b1;
                1: out_ready = ($urandom % 2) == 0;
                default: out_ready = ($urandom % 4) == 0;
            endcase

            // Sample well ahead of the next rising edge
            #(CLK_PERIOD / 4);
            if (!out_ready) begin
                check_value("in_ready while output stalled", 128'(1'b0), 128'(in_ready));
            end
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    stop_run("Output word appeared with no expected word left");
                end
                name = $sformatf("packet %0d word %0d", exp_pkt[0], exp_word[0]);
                check_value({name, " data"}, exp_data[0] & exp_mask[0],
                            out_data & exp_mask[0]);
                check_value({name, " last"}, 128'(exp_last[0]), 128'(out_last));
                if (exp_last[0]) begin
                    out_pkt++;
                end
                void'(exp_data.pop_front());
                void'(exp_mask.pop_front());
                void'(exp_last.pop_front());
                void'(exp_pkt.pop_front());
                void'(exp_word.pop_front());
            end
            holding = in_valid && !in_ready;
            if (in_valid && in_ready) begin
                void'(beat_data.pop_front());
                void'(beat_last.pop_front());
                void'(beat_offset.pop_front());
                void'(beat_len.pop_front());
            end
        end

        // Back to idle with no stray tail word
        @(negedge clk);
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            check_value("out_valid after last packet", 128'(1'b0), 128'(out_valid));
        end

        $display("Packets %0d, with tail word %0d, with zero offset %0d",
                 out_pkt, tail_packets, zero_offset_packets);
        if (tail_packets == 0 || zero_offset_packets == 0) begin
            stop_run("Random packets missed the tail word or zero offset cases");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule : stream_unalign_tb

`default_nettype wire

// ==== stream_unalign.f ====
+incdir+hw
hw/stream_unalign_pkg.sv
hw/shift_ctrl.sv
hw/carry_store.sv
hw/unit_merge.sv
hw/stream_unalign.sv
bench/stream_unalign_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the stream unaligner testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM=stream_unalign_sim
LOG=sim.log

verilator --binary --timing \
    -f stream_unalign.f \
    --top-module stream_unalign_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM"

# A failing run exits nonzero, the log decides the result
"./$BUILD_DIR/$SIM" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TEST OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
